// File: Bender.yml
package:
  name: tag_tracker

sources:
  # Packages first, the transaction package uses the heap types
  - files:
      - verilog/heap_cfg_pkg.sv
      - verilog/txn_pkg.sv
      - verilog/heap_ram.sv
      - verilog/heap_free_list.sv
      - verilog/req_issue.sv
      - verilog/rsp_merge.sv
      - verilog/tag_tracker_top.sv

  # Testbench and bound checker
  - target: test
    files:
      - test/tag_tracker_checker.sv
      - test/tag_tracker_tb.sv

// File: all.f
verilog/heap_cfg_pkg.sv
verilog/txn_pkg.sv
verilog/heap_ram.sv
verilog/heap_free_list.sv
verilog/req_issue.sv
verilog/rsp_merge.sv
verilog/tag_tracker_top.sv
test/tag_tracker_checker.sv
test/tag_tracker_tb.sv

// File: test/tag_tracker_checker.sv
// Protocol assertions on the tracker ports of every tag_tracker_top instance
// Stability holds for the client and downstream streams too
`timescale 1ns/1ps
`default_nettype none

module tag_tracker_checker
    import heap_cfg_pkg::*, txn_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   req_valid,
    input req_t   req,
    input logic   req_ready,
    input logic   issue_valid,
    input issue_t issue,
    input logic   issue_ready,
    input logic   rsp_valid,
    input rsp_t   rsp,
    input logic   rsp_ready,
    input logic   done_valid,
    input done_t  done,
    input logic   done_ready
);

    // Number of failed assertions
    int failures = 0;

    // ==================================================================
    // Valid and payload held while stalled
    // ==================================================================

    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req))
    else
    begin
        $error("request dropped or changed while stalled");
        failures++;
    end

    a_issue_hold: assert property (@(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue))
    else
    begin
        $error("issue dropped or changed while stalled");
        failures++;
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else
    begin
        $error("response dropped or changed while stalled");
        failures++;
    end

    a_done_hold: assert property (@(posedge clk) disable iff (reset)
        done_valid && !done_ready |=> done_valid && $stable(done))
    else
    begin
        $error("completion dropped or changed while stalled");
        failures++;
    end

    // Outputs idle right after reset
    a_idle_after_reset: assert property (@(posedge clk)
        reset |=> !issue_valid && !done_valid)
    else
    begin
        $error("issue_valid or done_valid high after reset");
        failures++;
    end

    // Issued tag known and within the heap
    a_tag_range: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> !$isunknown(issue.tag) && (int'(issue.tag) < N_ENTRIES))
    else
    begin
        $error("issued tag unknown or out of range");
        failures++;
    end

endmodule

bind tag_tracker_top tag_tracker_checker i_checker (.*);

`default_nettype wire

// File: test/tag_tracker_tb.sv
// Testbench for the tag tracker, a downstream model answers issued tags in random order
// Results are derived from the issued address, completions are checked in response order
// Request data is generated up front, all later randomness comes from the model process
`timescale 1ns/1ps
`default_nettype none

module tag_tracker_tb
    import heap_cfg_pkg::*, txn_pkg::*;
();

    // ==================================================================
    // Run sizing
    // ==================================================================

    localparam int N_REQS         = 100;
    localparam int STALL_MARGIN   = 20;
    localparam int STARTUP_CYCLES = 4 * N_ENTRIES + 40;
    localparam int TIMEOUT_CYCLES = N_REQS * STALL_MARGIN + STARTUP_CYCLES;
    // Cycles without acceptance that count as a full tracker
    localparam int FILL_WAIT      = 30;
    localparam int ACCEPT_WAIT    = 200;

    logic   clk;
    logic   reset;
    logic   req_valid;
    req_t   req;
    logic   req_ready;
    logic   issue_valid;
    issue_t issue;
    logic   issue_ready;
    logic   rsp_valid;
    rsp_t   rsp;
    logic   rsp_ready;
    logic   done_valid;
    done_t  done;
    logic   done_ready;

    int seed = 61909;
    req_t reqs [0:N_REQS-1];
    int next_req = 0;
    int issue_count = 0;
    int done_count = 0;
    int outstanding = 0;
    int cycle_count = 0;
    int errors = 0;
    int checks = 0;
    int test_errors = 0;
    int filled;
    int pick;
    bit ok;
    tag_t pick_tag;

    // Downstream model state, indexed by tag
    logic [COOKIE_BITS-1:0] cookie_by_tag [0:N_ENTRIES-1];
    logic [ADDR_BITS-1:0]   addr_by_tag [0:N_ENTRIES-1];
    logic                   busy [0:N_ENTRIES-1];
    tag_t                   pending [$];
    done_t                  exp_q [$];
    logic                   rsp_en;
    logic                   stall_en;

    tag_tracker_top i_dut (.*);

    always #50 clk = ~clk;

    // ==================================================================
    // Reference model and checks
    // ==================================================================

    // Result returned downstream for an address
    function automatic logic [RESULT_BITS-1:0] result_for(input logic [ADDR_BITS-1:0] addr);
        return {addr ^ 16'hc3a5, ~addr};
    endfunction

    // Completion expected for a request cookie and its issued address
    function automatic done_t expected_done(input logic [COOKIE_BITS-1:0] cookie,
                                            input logic [ADDR_BITS-1:0] addr);
        done_t d;
        d.cookie = cookie;
        d.result = result_for(addr);
        return d;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("Failure at cycle %0d: %s", cycle_count, msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d error(s)", name, errors - test_errors);
        test_errors = errors;
    endtask

    // ==================================================================
    // Client side tasks, called on a rising edge
    // ==================================================================

    task automatic drive_next();
        req_valid <= 1'b1;
        req       <= reqs[next_req];
    endtask

    // Holds the request until taken or until limit edges have passed
    task automatic wait_accept(input int limit, output bit accepted);
        int i;
        accepted = 1'b0;
        i = 0;
        while (!accepted && i < limit)
        begin
            @(posedge clk);
            if (req_ready)
                accepted = 1'b1;
            i++;
        end
        if (accepted)
            next_req++;
    endtask

    task automatic idle_req();
        req_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        do
            @(negedge clk);
        while (done_count != next_req);
        // Quiet period to catch late or duplicated completions
        repeat (8) @(negedge clk);
        @(posedge clk);
    endtask

    // ==================================================================
    // Downstream model, captures issues and answers in random order
    // ==================================================================

    always @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            // Issues leave in request order
            if (issue_valid && issue_ready)
            begin
                check_value("issue.addr", issue.addr, reqs[issue_count].addr);
                if (busy[issue.tag])
                    note_failure($sformatf("tag %0d issued while still outstanding", issue.tag));
                busy[issue.tag]          = 1'b1;
                cookie_by_tag[issue.tag] = reqs[issue_count].cookie;
                addr_by_tag[issue.tag]   = issue.addr;
                pending.push_back(issue.tag);
                issue_count++;
                outstanding++;
                if (outstanding > N_ENTRIES - 2)
                    note_failure($sformatf("%0d tags outstanding at once", outstanding));
            end
            // Accepted response, its completion comes out next in order
            if (rsp_valid && rsp_ready)
            begin
                exp_q.push_back(expected_done(cookie_by_tag[rsp.tag], addr_by_tag[rsp.tag]));
                busy[rsp.tag] = 1'b0;
                outstanding--;
            end
            if (rsp_en && pending.size() > 0 && (!rsp_valid || rsp_ready))
            begin
                pick     = ($random(seed) & 32'h7fff_ffff) % pending.size();
                pick_tag = pending[pick];
                pending.delete(pick);
                rsp_valid  <= 1'b1;
                rsp.tag    <= pick_tag;
                rsp.result <= result_for(addr_by_tag[pick_tag]);
            end
            else if (rsp_valid && rsp_ready)
            begin
                rsp_valid <= 1'b0;
            end
            // Back-pressure, ready about three cycles in four
            if (stall_en)
            begin
                issue_ready <= ($random(seed) & 3) != 0;
                done_ready  <= ($random(seed) & 3) != 0;
            end
            else
            begin
                issue_ready <= 1'b1;
                done_ready  <= 1'b1;
            end
        end
    end

    // Compare each completion with the head of the expected queue
    always @(posedge clk)
    begin
        if (!reset && done_valid && done_ready)
        begin
            if (exp_q.size() == 0)
                note_failure("completion arrived with no response outstanding");
            else
                check_value("done", done, exp_q.pop_front());
            done_count++;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        issue_ready = 1'b1;
        rsp_valid   = 1'b0;
        rsp         = '0;
        done_ready  = 1'b1;
        rsp_en      = 1'b0;
        stall_en    = 1'b0;
        for (int i = 0; i < N_ENTRIES; i++)
            busy[i] = 1'b0;
        for (int i = 0; i < N_REQS; i++)
        begin
            reqs[i].addr   = $random(seed);
            reqs[i].cookie = $random(seed);
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Start-up, heap links its entries before taking requests
        @(negedge clk);
        check_value("req_ready", req_ready, 0);
        check_value("done_valid", done_valid, 0);
        while (!req_ready)
            @(negedge clk);
        end_test("reset and start-up");

        @(posedge clk);
        rsp_en <= 1'b1;
        drive_next();
        wait_accept(ACCEPT_WAIT, ok);
        idle_req();
        if (!ok)
            note_failure("single request was not accepted");
        wait_drained();
        check_value("issue_count", issue_count, 1);
        check_value("done_count", done_count, 1);
        end_test("single request");

        // Responses withheld, last request stays pending when the tags run out
        rsp_en <= 1'b0;
        filled = 0;
        ok     = 1'b1;
        while (ok && filled < N_ENTRIES)
        begin
            drive_next();
            wait_accept(FILL_WAIT, ok);
            if (ok)
                filled++;
        end
        if (ok)
            note_failure("req_ready never fell while responses were withheld");
        end_test("fill without responses");

        rsp_en <= 1'b1;
        wait_accept(ACCEPT_WAIT, ok);
        if (!ok)
            note_failure("held request was not accepted after responses resumed");
        for (int i = 0; i < 20; i++)
        begin
            drive_next();
            wait_accept(ACCEPT_WAIT, ok);
            if (!ok)
                note_failure("request was not accepted");
        end
        idle_req();
        wait_drained();
        check_value("completions", done_count, next_req);
        end_test("out-of-order responses");

        // Random stalls on both downstream ready and client ready
        stall_en <= 1'b1;
        for (int i = 0; i < 60; i++)
        begin
            drive_next();
            wait_accept(ACCEPT_WAIT, ok);
            if (!ok)
                note_failure("request was not accepted under stalls");
        end
        idle_req();
        wait_drained();
        stall_en <= 1'b0;
        check_value("completions", done_count, next_req);
        check_value("issues", issue_count, next_req);
        end_test("random stalls and tag reuse");

        errors += i_dut.i_checker.failures;
        $display("Tests run: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/heap_cfg_pkg.sv
// Tag heap sizing shared by the free list, the payload memory and the top level
// N_ENTRIES must be a power of two and above MIN_FREE_SLOTS + 2
// Two entries stay parked as list heads and are never handed out
`default_nettype none

package heap_cfg_pkg;

    // ==================================================================
    // Sizing
    // ==================================================================

    // Total number of tags in the heap
    localparam int N_ENTRIES = 16;

    // Allocation stops once the free count drops to this level
    localparam int MIN_FREE_SLOTS = 1;

    // Width of a tag index
    localparam int TAG_BITS = $clog2(N_ENTRIES);

    // ==================================================================
    // Types
    // ==================================================================

    // Tag index, also the address into the link and payload memories
    typedef logic [TAG_BITS-1:0] tag_t;

    // Free entry count, one bit wider than a tag
    typedef logic [TAG_BITS:0] free_cnt_t;

endpackage

`default_nettype wire

// File: verilog/heap_free_list.sv
// Free-list tag allocator, free tags are kept as two linked lists in a link memory
// not_full stays low for about N_ENTRIES cycles after reset while the lists are built
// alloc is legal only while not_full is high, a freed tag is credited a cycle later
`timescale 1ns/1ps
`default_nettype none

module heap_free_list
    import heap_cfg_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Allocation side
    input  logic alloc,
    output logic not_full,
    output tag_t alloc_idx,

    // Release side
    input  logic free,
    input  tag_t free_idx
);

    // ==================================================================
    // Prefetch queue, two entries, head presented as alloc_idx
    // ==================================================================

    tag_t       q_data [0:1];
    logic [1:0] q_cnt;
    logic       pop_free;
    logic       free_idx_avail;
    logic       free_idx_above_min;
    tag_t       next_free_idx;

    // Pull from a list whenever the queue has room and a tag is free
    assign pop_free = (q_cnt != 2'd2) && free_idx_avail;

    assign alloc_idx = q_data[0];
    assign not_full  = (q_cnt != 2'd0) && free_idx_above_min;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            q_cnt <= 2'd0;
        end
        else
        begin
            q_cnt <= q_cnt + {1'b0, pop_free} - {1'b0, alloc};
        end
    end

    always_ff @(posedge clk)
    begin
        // Shift on allocation
        if (alloc)
        begin
            q_data[0] <= q_data[1];
        end

        // New tag lands in the first slot that is empty after the shift
        if (pop_free)
        begin
            if ((q_cnt == 2'd0) || ((q_cnt == 2'd1) && alloc))
            begin
                q_data[0] <= next_free_idx;
            end
            else
            begin
                q_data[1] <= next_free_idx;
            end
        end
    end

    // ==================================================================
    // Two free lists, heads and tails served round-robin
    // ==================================================================

    tag_t head_idx [0:1];
    tag_t tail_idx [0:1];
    logic head_sel;
    logic tail_sel;
    logic pop_free_q;
    logic initialized;
    tag_t init_idx;
    logic link_wen;
    tag_t link_wdata;
    tag_t link_rdata;
    logic free_q;
    tag_t free_idx_q;

    // The tag handed out is the current head, its link gives the next head
    assign next_free_idx = head_idx[head_sel];

    // During start-up the link memory is filled with the initial chain
    assign link_wen   = !initialized || free_q;
    assign link_wdata = initialized ? free_idx_q : init_idx;

    heap_ram #(
        .N_WORDS   (N_ENTRIES),
        .WORD_BITS (TAG_BITS)
    ) i_link_ram (
        .clk   (clk),
        .wen   (link_wen),
        .waddr (tail_idx[tail_sel]),
        .wdata (link_wdata),
        .raddr (head_idx[head_sel]),
        .rdata (link_rdata)
    );

    // Head pointers
    // A list popped last cycle gets its new head from the link read,
    // meanwhile the other list serves, which hides the read latency
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pop_free_q  <= 1'b0;
            head_sel    <= 1'b0;
            head_idx[0] <= tag_t'(0);
            head_idx[1] <= tag_t'(1);
        end
        else
        begin
            pop_free_q <= pop_free;
            if (pop_free)
            begin
                head_sel <= ~head_sel;
            end
            // Selector has already toggled, so the popped list is the other one
            if (pop_free_q)
            begin
                head_idx[~head_sel] <= link_rdata;
            end
        end
    end

    // Release is pushed onto a tail one cycle after it arrives
    always_ff @(posedge clk)
    begin
        free_idx_q <= free_idx;
    end

    // Tail pointers and start-up linking, entries 0 and 1 begin as heads
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_q      <= 1'b0;
            tail_idx[0] <= tag_t'(0);
            tail_idx[1] <= tag_t'(1);
            tail_sel    <= 1'b0;
            init_idx    <= tag_t'(2);
            initialized <= 1'b0;
        end
        else
        begin
            free_q <= free;
            if (link_wen)
            begin
                tail_idx[tail_sel] <= link_wdata;
                tail_sel           <= ~tail_sel;
            end
            // One entry linked per cycle
            if (!initialized)
            begin
                init_idx <= init_idx + tag_t'(1);
                if (init_idx == tag_t'(N_ENTRIES - 1))
                begin
                    initialized <= 1'b1;
                end
            end
        end
    end

    // ==================================================================
    // Free count, the two head entries are never counted
    // ==================================================================

    free_cnt_t num_free;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            num_free <= free_cnt_t'(N_ENTRIES - 2);
        end
        else if (free_q && !pop_free)
        begin
            num_free <= num_free + free_cnt_t'(1);
        end
        else if (!free_q && pop_free)
        begin
            num_free <= num_free - free_cnt_t'(1);
        end
    end

    assign free_idx_avail     = initialized && (num_free != free_cnt_t'(0));
    assign free_idx_above_min = initialized && (num_free > free_cnt_t'(MIN_FREE_SLOTS));

endmodule

`default_nettype wire

// File: verilog/heap_ram.sv
// Simple dual-port memory, one write port and one registered read port
// Read data appears one cycle after the address, contents are not reset
// A read and a write to the same word in one cycle return the old word
`timescale 1ns/1ps
`default_nettype none

module heap_ram #(
    parameter int N_WORDS   = 16,
    parameter int WORD_BITS = 32
) (
    input  logic                       clk,

    // Write port
    input  logic                       wen,
    input  logic [$clog2(N_WORDS)-1:0] waddr,
    input  logic [WORD_BITS-1:0]       wdata,

    // Read port
    input  logic [$clog2(N_WORDS)-1:0] raddr,
    output logic [WORD_BITS-1:0]       rdata
);

    // Storage array
    logic [WORD_BITS-1:0] mem [0:N_WORDS-1];

    // Write
    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: verilog/req_issue.sv
// Request side, takes a tag per request and issues the tag with the address
// The cookie is written to the payload memory in the acceptance cycle
// One issue register, so issue_valid follows acceptance by one cycle
`timescale 1ns/1ps
`default_nettype none

module req_issue
    import heap_cfg_pkg::*, txn_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // Client requests
    input  logic                   req_valid,
    input  req_t                   req,
    output logic                   req_ready,

    // Downstream issue
    output logic                   issue_valid,
    output issue_t                 issue,
    input  logic                   issue_ready,

    // Heap allocation
    input  logic                   not_full,
    input  tag_t                   alloc_idx,
    output logic                   alloc,

    // Payload memory write port
    output logic                   pay_wen,
    output tag_t                   pay_waddr,
    output logic [COOKIE_BITS-1:0] pay_wdata
);

    logic accept;

    // Room when a tag is ready and the issue register empties this cycle
    assign req_ready = not_full && (!issue_valid || issue_ready);
    assign accept    = req_valid && req_ready;

    // Consume the prefetched tag and park the cookie under it
    assign alloc     = accept;
    assign pay_wen   = accept;
    assign pay_waddr = alloc_idx;
    assign pay_wdata = req.cookie;

    // Issue register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            issue_valid <= 1'b0;
        end
        else if (accept)
        begin
            issue_valid <= 1'b1;
        end
        else if (issue_ready)
        begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            issue.tag  <= alloc_idx;
            issue.addr <= req.addr;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rsp_merge.sv
// Response side, joins each result with the cookie stored under its tag
// The payload read is one cycle, so done_valid follows acceptance by one cycle
// The tag goes back to the heap in the cycle its completion is taken
`timescale 1ns/1ps
`default_nettype none

module rsp_merge
    import heap_cfg_pkg::*, txn_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // Downstream responses
    input  logic                   rsp_valid,
    input  rsp_t                   rsp,
    output logic                   rsp_ready,

    // Payload memory read port
    output tag_t                   pay_raddr,
    input  logic [COOKIE_BITS-1:0] pay_rdata,

    // Completions to the client
    output logic                   done_valid,
    output done_t                  done,
    input  logic                   done_ready,

    // Tag release
    output logic                   free,
    output tag_t                   free_idx
);

    logic                   accept;
    logic                   cookie_live;
    tag_t                   tag_q;
    logic [RESULT_BITS-1:0] result_q;
    logic [COOKIE_BITS-1:0] cookie_q;

    assign rsp_ready = !done_valid || done_ready;
    assign accept    = rsp_valid && rsp_ready;

    // Look up the cookie as soon as the response is seen
    assign pay_raddr = rsp.tag;

    // Completion register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            done_valid  <= 1'b0;
            cookie_live <= 1'b0;
        end
        else
        begin
            cookie_live <= accept;
            if (accept)
            begin
                done_valid <= 1'b1;
            end
            else if (done_ready)
            begin
                done_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            tag_q    <= rsp.tag;
            result_q <= rsp.result;
        end
        // Cookie is valid on the read port only in the first cycle, keep a copy
        if (cookie_live)
        begin
            cookie_q <= pay_rdata;
        end
    end

    // Read port in the first cycle, held copy while stalled
    always_comb
    begin
        done.cookie = cookie_live ? pay_rdata : cookie_q;
        done.result = result_q;
    end

    // Release the tag once the client has taken the completion
    assign free     = done_valid && done_ready;
    assign free_idx = tag_q;

endmodule

`default_nettype wire

// File: verilog/tag_tracker_top.sv
// Outstanding-request tag tracker, up to N_ENTRIES - 2 tags minus the free threshold
// Requests stall after reset until the tag heap has finished linking
`timescale 1ns/1ps
`default_nettype none

module tag_tracker_top
    import heap_cfg_pkg::*, txn_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    // Client requests
    input  logic   req_valid,
    input  req_t   req,
    output logic   req_ready,

    // Downstream issue
    output logic   issue_valid,
    output issue_t issue,
    input  logic   issue_ready,

    // Downstream responses
    input  logic   rsp_valid,
    input  rsp_t   rsp,
    output logic   rsp_ready,

    // Completions
    output logic   done_valid,
    output done_t  done,
    input  logic   done_ready
);

    // ==================================================================
    // Internal wiring
    // ==================================================================

    logic                   not_full;
    tag_t                   alloc_idx;
    logic                   alloc;
    logic                   free;
    tag_t                   free_idx;
    logic                   pay_wen;
    tag_t                   pay_waddr;
    logic [COOKIE_BITS-1:0] pay_wdata;
    tag_t                   pay_raddr;
    logic [COOKIE_BITS-1:0] pay_rdata;

    // Input side
    req_issue i_req_issue (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .not_full    (not_full),
        .alloc_idx   (alloc_idx),
        .alloc       (alloc),
        .pay_wen     (pay_wen),
        .pay_waddr   (pay_waddr),
        .pay_wdata   (pay_wdata)
    );

    // Tag heap
    heap_free_list i_heap_free_list (
        .clk       (clk),
        .reset     (reset),
        .alloc     (alloc),
        .not_full  (not_full),
        .alloc_idx (alloc_idx),
        .free      (free),
        .free_idx  (free_idx)
    );

    // Cookie storage indexed by tag
    heap_ram #(
        .N_WORDS   (N_ENTRIES),
        .WORD_BITS (COOKIE_BITS)
    ) i_payload_ram (
        .clk   (clk),
        .wen   (pay_wen),
        .waddr (pay_waddr),
        .wdata (pay_wdata),
        .raddr (pay_raddr),
        .rdata (pay_rdata)
    );

    // Output side
    rsp_merge i_rsp_merge (
        .clk        (clk),
        .reset      (reset),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_ready  (rsp_ready),
        .pay_raddr  (pay_raddr),
        .pay_rdata  (pay_rdata),
        .done_valid (done_valid),
        .done       (done),
        .done_ready (done_ready),
        .free       (free),
        .free_idx   (free_idx)
    );

endmodule

`default_nettype wire

// File: verilog/txn_pkg.sv
// Transaction payloads for the four valid/ready streams of the tracker
// Tags come from heap_cfg_pkg, so that package compiles first
`default_nettype none

package txn_pkg;
    import heap_cfg_pkg::*;

    // Field widths
    localparam int ADDR_BITS   = 16;
    localparam int COOKIE_BITS = 32;
    localparam int RESULT_BITS = 32;

    // Client request
    typedef struct packed {
        logic [ADDR_BITS-1:0]   addr;
        logic [COOKIE_BITS-1:0] cookie;
    } req_t;

    // Tagged request sent downstream, cookie stays behind in the payload memory
    typedef struct packed {
        tag_t                   tag;
        logic [ADDR_BITS-1:0]   addr;
    } issue_t;

    // Downstream response, may come back in any order
    typedef struct packed {
        tag_t                   tag;
        logic [RESULT_BITS-1:0] result;
    } rsp_t;

    // Completion returned to the client
    typedef struct packed {
        logic [COOKIE_BITS-1:0] cookie;
        logic [RESULT_BITS-1:0] result;
    } done_t;

endpackage

`default_nettype wire
